//--- Makefile
# Verilator build and run of the front-end recovery testbench

TB_TOP = frontend_tb

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TB_TOP)

obj_dir/V$(TB_TOP): verilog.f $(shell cat verilog.f)
	verilator --binary --timing -j 0 --timescale 1ns/1ps \
		--top-module $(TB_TOP) -f verilog.f -o V$(TB_TOP)

# the log decides, since tee hides the simulator's exit status
run: build
	./obj_dir/V$(TB_TOP) 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "Test passed" sim.log || (echo "simulation ended without passing"; exit 1)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module frontend_top -f verilog.f

clean:
	rm -rf obj_dir sim.log

//--- common/recover_pkg.sv
`default_nettype none

package recover_pkg;

	localparam int addr_width = 64;
	localparam int bhr_width = 6;
	localparam int pht_entries = 1 << bhr_width;
	localparam int btb_entries = 16;
	localparam int btb_index_width = $clog2(btb_entries);

	typedef logic [addr_width-1:0] addr_t;
	typedef logic [bhr_width-1:0] bhr_t;
	typedef logic [1:0] retire_num_t; // 0, 1 or 2 per cycle
	typedef logic [1:0] counter_t; // msb set predicts taken
	typedef logic [btb_index_width-1:0] btb_index_t;

	localparam addr_t reset_vector = 64'h1000;
	localparam addr_t inst_bytes = 64'd4;

	localparam counter_t counter_init = 2'd1; // weakly not taken

	// one retirement slot as the ROB presents it
	typedef struct packed {
		logic cond_branch;
		logic uncond_branch;
		bhr_t bhr; // history seen when the branch was predicted
		addr_t npc; // address after the branch
		addr_t actual_addr; // resolved next address
	} rob_slot_t;

endpackage

`default_nettype wire

//--- hw/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc import recover_pkg::*; (
	input logic clock,
	input logic reset,

	input logic if_recover,
	input addr_t if_recover_addr,
	input logic btb_hit,
	input addr_t btb_target,

	output addr_t fetch_addr
);

	addr_t seq_addr;
	addr_t next_addr;

	assign seq_addr = fetch_addr + inst_bytes;

	// redirect beats predicted target beats fall-through
	always_comb begin
		if (if_recover)
			next_addr = if_recover_addr;
		else if (btb_hit)
			next_addr = btb_target;
		else
			next_addr = seq_addr;
	end

	always_ff @(posedge clock) begin
		if (reset)
			fetch_addr <= reset_vector;
		else
			fetch_addr <= next_addr; // no stalls in this front end
	end

endmodule

`default_nettype wire

//--- hw/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top import recover_pkg::*; (
	input logic clock,
	input logic reset,

	input retire_num_t rob_retire_num,
	input logic rob_exception,
	input rob_slot_t rob_slot0,
	input rob_slot_t rob_slot1,

	output addr_t fetch_addr,
	output logic pred_taken,
	output logic fl_recover,
	output logic mt_recover,
	output logic other_flush
);

	logic if_recover;
	addr_t if_recover_addr;
	logic bht_recover;
	bhr_t bht_bhr;
	logic btb_recover;
	addr_t btb_npc;
	addr_t btb_actual_addr;
	logic btb_hit;
	addr_t btb_target;

	recover u_recover (
		.clock(clock),
		.reset(reset),
		.rob_retire_num(rob_retire_num),
		.rob_exception(rob_exception),
		.rob_slot0(rob_slot0),
		.rob_slot1(rob_slot1),
		.if_recover(if_recover),
		.if_recover_addr(if_recover_addr),
		.bht_recover(bht_recover),
		.bht_bhr(bht_bhr),
		.btb_recover(btb_recover),
		.btb_npc(btb_npc),
		.btb_actual_addr(btb_actual_addr),
		.fl_recover(fl_recover),
		.mt_recover(mt_recover),
		.other_flush(other_flush)
	);

	bht u_bht (
		.clock(clock),
		.reset(reset),
		.bht_recover(bht_recover),
		.bht_bhr(bht_bhr),
		.btb_hit(btb_hit),
		.pred_taken(pred_taken)
	);

	btb u_btb (
		.clock(clock),
		.reset(reset),
		.btb_recover(btb_recover),
		.btb_npc(btb_npc),
		.btb_actual_addr(btb_actual_addr),
		.fetch_addr(fetch_addr),
		.btb_hit(btb_hit),
		.btb_target(btb_target)
	);

	// fetch address loops back into both predictors
	fetch_pc u_fetch_pc (
		.clock(clock),
		.reset(reset),
		.if_recover(if_recover),
		.if_recover_addr(if_recover_addr),
		.btb_hit(btb_hit),
		.btb_target(btb_target),
		.fetch_addr(fetch_addr)
	);

endmodule

`default_nettype wire

//--- hw/recover.sv
`timescale 1ns/1ps
`default_nettype none

module recover import recover_pkg::*; (
	input logic clock,
	input logic reset,

	input retire_num_t rob_retire_num,
	input logic rob_exception,
	input rob_slot_t rob_slot0,
	input rob_slot_t rob_slot1,

	output logic if_recover,
	output addr_t if_recover_addr,
	output logic bht_recover,
	output bhr_t bht_bhr,
	output logic btb_recover,
	output addr_t btb_npc,
	output addr_t btb_actual_addr,
	output logic fl_recover,
	output logic mt_recover,
	output logic other_flush
);

	logic lockout; // a recovery went out last cycle
	logic accept;
	rob_slot_t slot;

	logic next_if_recover;
	logic next_bht_recover;
	logic next_btb_recover;
	logic next_flush;

	// excepting instruction is the last one retired
	always_comb begin
		slot = (rob_retire_num == 2'd2) ? rob_slot1 : rob_slot0;
		accept = rob_exception && (rob_retire_num != 2'd0) && !lockout;

		next_if_recover = 1'b0;
		next_bht_recover = 1'b0;
		next_btb_recover = 1'b0;
		next_flush = 1'b0;

		if (accept) begin
			next_if_recover = 1'b1;
			next_flush = 1'b1; // free list, map table and the rest
			if (slot.cond_branch)
				next_bht_recover = 1'b1;
			else if (slot.uncond_branch)
				next_btb_recover = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lockout <= 1'b0;
			if_recover <= 1'b0;
			bht_recover <= 1'b0;
			btb_recover <= 1'b0;
			fl_recover <= 1'b0;
			mt_recover <= 1'b0;
			other_flush <= 1'b0;
		end else begin
			lockout <= accept; // one cycle only
			if_recover <= next_if_recover;
			bht_recover <= next_bht_recover;
			btb_recover <= next_btb_recover;
			fl_recover <= next_flush;
			mt_recover <= next_flush;
			other_flush <= next_flush;
		end
	end

	// payload only looked at while a pulse is high
	always_ff @(posedge clock) begin
		if_recover_addr <= slot.actual_addr;
		bht_bhr <= slot.bhr;
		btb_npc <= slot.npc;
		btb_actual_addr <= slot.actual_addr;
	end

endmodule

`default_nettype wire

//--- predictor/bht.sv
`timescale 1ns/1ps
`default_nettype none

module bht import recover_pkg::*; (
	input logic clock,
	input logic reset,

	input logic bht_recover,
	input bhr_t bht_bhr,
	input logic btb_hit,

	output logic pred_taken
);

	bhr_t history;
	counter_t pht [pht_entries];
	counter_t old_counter;
	counter_t fixed_counter;

	// pattern table indexed by global history alone
	assign pred_taken = pht[history][1];

	// retrain the counter that made the wrong call
	always_comb begin
		old_counter = pht[bht_bhr];
		if (old_counter[1]) begin
			fixed_counter = old_counter - 2'd1;
		end else begin
			fixed_counter = old_counter + 2'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			history <= '0;
		end else if (bht_recover) begin
			history <= bht_bhr; // repair to the branch's view
		end else if (btb_hit) begin
			history <= {history[bhr_width-2:0], pred_taken}; // speculative shift
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < pht_entries; i++)
				pht[i] <= counter_init;
		end else if (bht_recover) begin
			pht[bht_bhr] <= fixed_counter;
		end
	end

endmodule

`default_nettype wire

//--- predictor/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb import recover_pkg::*; (
	input logic clock,
	input logic reset,

	input logic btb_recover,
	input addr_t btb_npc,
	input addr_t btb_actual_addr,
	input addr_t fetch_addr,

	output logic btb_hit,
	output addr_t btb_target
);

	logic [btb_entries-1:0] valid;
	addr_t tag_mem [btb_entries];
	addr_t target_mem [btb_entries];

	addr_t branch_addr;
	btb_index_t wr_index;
	btb_index_t rd_index;

	// npc is one instruction past the branch itself
	assign branch_addr = btb_npc - inst_bytes;
	assign wr_index = branch_addr[btb_index_width+1:2];

	// lookup in the same cycle as the fetch address
	assign rd_index = fetch_addr[btb_index_width+1:2];
	assign btb_hit = valid[rd_index] && (tag_mem[rd_index] == fetch_addr);
	assign btb_target = target_mem[rd_index];

	always_ff @(posedge clock) begin
		if (reset)
			valid <= '0;
		else if (btb_recover)
			valid[wr_index] <= 1'b1;
	end

	// full address tag with no partial compare
	always_ff @(posedge clock) begin
		if (btb_recover) begin
			tag_mem[wr_index] <= branch_addr;
			target_mem[wr_index] <= btb_actual_addr;
		end
	end

endmodule

`default_nettype wire

//--- tests/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb import recover_pkg::*; ();

	localparam int random_iters = 300;
	localparam int test_cycles = 80 + random_iters * 7;

	logic clock;
	logic reset;
	retire_num_t rob_retire_num;
	logic rob_exception;
	rob_slot_t rob_slot0;
	rob_slot_t rob_slot1;

	addr_t fetch_addr;
	logic pred_taken;
	logic fl_recover;
	logic mt_recover;
	logic other_flush;

	// reference model state
	logic m_lockout;
	logic m_if_rec;
	logic m_bht_rec;
	logic m_btb_rec;
	logic m_flush;
	addr_t m_rec_addr;
	bhr_t m_bhr;
	addr_t m_npc;
	addr_t m_actual;
	bhr_t m_history;
	counter_t m_pht [pht_entries];
	logic [btb_entries-1:0] m_valid;
	addr_t m_tag [btb_entries];
	addr_t m_target [btb_entries];
	addr_t m_pc;

	frontend_top frontend_top_inst (
		.clock(clock),
		.reset(reset),
		.rob_retire_num(rob_retire_num),
		.rob_exception(rob_exception),
		.rob_slot0(rob_slot0),
		.rob_slot1(rob_slot1),
		.fetch_addr(fetch_addr),
		.pred_taken(pred_taken),
		.fl_recover(fl_recover),
		.mt_recover(mt_recover),
		.other_flush(other_flush)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// one step away from the current prediction
	function automatic counter_t retrained(input counter_t c);
		case (c)
			2'd0: return 2'd1;
			2'd1: return 2'd2;
			2'd2: return 2'd1;
			default: return 2'd2;
		endcase
	endfunction

	function automatic btb_index_t btb_index_of(input addr_t a);
		return a[5:2];
	endfunction

	function automatic logic btb_match(input addr_t pc);
		return m_valid[btb_index_of(pc)] && (m_tag[btb_index_of(pc)] == pc);
	endfunction

	function automatic addr_t next_fetch_addr(input logic redirect, input addr_t redirect_addr,
			input logic hit, input addr_t target, input addr_t pc);
		if (redirect)
			return redirect_addr;
		if (hit)
			return target;
		return pc + inst_bytes;
	endfunction

	always @(posedge clock) begin : model_step
		logic hit;
		logic pred;
		logic acc;
		addr_t target;
		addr_t branch;
		rob_slot_t s;
		hit = btb_match(m_pc);
		pred = m_pht[m_history][1];
		target = m_target[btb_index_of(m_pc)];
		s = (rob_retire_num == 2'd2) ? rob_slot1 : rob_slot0; // last retired slot
		if (reset) begin
			m_lockout = 1'b0;
			m_if_rec = 1'b0;
			m_bht_rec = 1'b0;
			m_btb_rec = 1'b0;
			m_flush = 1'b0;
			m_history = '0;
			for (int i = 0; i < pht_entries; i++)
				m_pht[i] = 2'd1;
			m_valid = '0;
			m_pc = reset_vector;
		end else begin
			if (m_bht_rec) begin
				m_pht[m_bhr] = retrained(m_pht[m_bhr]);
				m_history = m_bhr;
			end else if (hit) begin
				m_history = {m_history[bhr_width-2:0], pred};
			end
			if (m_btb_rec) begin
				branch = m_npc - inst_bytes;
				m_valid[btb_index_of(branch)] = 1'b1;
				m_tag[btb_index_of(branch)] = branch;
				m_target[btb_index_of(branch)] = m_actual;
			end
			m_pc = next_fetch_addr(m_if_rec, m_rec_addr, hit, target, m_pc);
			acc = rob_exception && (rob_retire_num != 2'd0) && !m_lockout;
			m_lockout = acc;
			m_if_rec = acc;
			m_bht_rec = acc && s.cond_branch;
			m_btb_rec = acc && s.uncond_branch && !s.cond_branch;
			m_flush = acc;
		end
		m_rec_addr = s.actual_addr;
		m_bhr = s.bhr;
		m_npc = s.npc;
		m_actual = s.actual_addr;
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
			$display("Test failed");
			$fatal(1, "stopping at first wrong value");
		end
	endtask

	// compare every cycle away from the edges
	initial begin
		@(negedge reset);
		forever begin
			@(negedge clock);
			check_value("fetch_addr", fetch_addr, m_pc);
			check_value("pred_taken", 64'(pred_taken), 64'(m_pht[m_history][1]));
			check_value("fl_recover", 64'(fl_recover), 64'(m_flush));
			check_value("mt_recover", 64'(mt_recover), 64'(m_flush));
			check_value("other_flush", 64'(other_flush), 64'(m_flush));
		end
	end

	initial begin
		#(test_cycles * 10 + 200);
		$display("timeout: stimulus did not finish in %0d cycles", test_cycles);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic drive_retire(input retire_num_t num, input logic exc,
			input rob_slot_t s0, input rob_slot_t s1);
		rob_retire_num = num;
		rob_exception = exc;
		rob_slot0 = s0;
		rob_slot1 = s1;
	endtask

	function automatic rob_slot_t make_slot(input logic cond, input logic uncond,
			input bhr_t h, input addr_t npc, input addr_t actual);
		rob_slot_t s;
		s.cond_branch = cond;
		s.uncond_branch = uncond;
		s.bhr = h;
		s.npc = npc;
		s.actual_addr = actual;
		return s;
	endfunction

	// small window so fetch runs into installed branches
	function automatic addr_t random_addr();
		return 64'h1000 + 64'($urandom_range(0, 127)) * 64'd4;
	endfunction

	function automatic rob_slot_t random_slot();
		logic [1:0] kind;
		kind = 2'($urandom_range(0, 3));
		return make_slot(kind[0], kind[1], bhr_t'($urandom_range(0, 63)),
			random_addr(), random_addr());
	endfunction

	// exception seen at the next edge, pulses for one cycle, then the redirect
	task automatic recover_once(input retire_num_t num, input rob_slot_t s0, input rob_slot_t s1);
		addr_t expected;
		expected = (num == 2'd2) ? s1.actual_addr : s0.actual_addr;
		drive_retire(num, 1'b1, s0, s1);
		next_cycle();
		drive_retire(2'd0, 1'b0, '0, '0);
		check_value("fl_recover", 64'(fl_recover), 64'd1);
		check_value("mt_recover", 64'(mt_recover), 64'd1);
		check_value("other_flush", 64'(other_flush), 64'd1);
		next_cycle();
		check_value("fetch_addr", fetch_addr, expected);
		check_value("fl_recover", 64'(fl_recover), 64'd0);
	endtask

	initial begin
		addr_t branch;
		int gap;
		int hold;
		void'($urandom(32'h48b4_d859));
		reset = 1'b1;
		drive_retire(2'd0, 1'b0, '0, '0);
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		check_value("fetch_addr", fetch_addr, reset_vector);
		check_value("fl_recover", 64'(fl_recover), 64'd0);
		repeat (4) next_cycle();
		check_value("fetch_addr", fetch_addr, reset_vector + 64'd16);

		recover_once(2'd1, make_slot(1'b0, 1'b0, '0, 64'h1104, 64'h1800), '0);
		recover_once(2'd2, make_slot(1'b1, 1'b0, 6'h11, 64'h1204, 64'h1900),
			make_slot(1'b0, 1'b0, '0, 64'h1304, 64'h1a00));

		// held exception with the middle cycle locked out
		drive_retire(2'd1, 1'b1, make_slot(1'b0, 1'b0, '0, 64'h1404, 64'h1b00), '0);
		next_cycle();
		check_value("fl_recover", 64'(fl_recover), 64'd1);
		next_cycle();
		check_value("fl_recover", 64'(fl_recover), 64'd0);
		next_cycle();
		drive_retire(2'd0, 1'b0, '0, '0);
		check_value("fl_recover", 64'(fl_recover), 64'd1);
		next_cycle();

		// install a jump, then steer fetch back onto it
		branch = 64'h2040;
		recover_once(2'd1, make_slot(1'b0, 1'b1, '0, branch + 64'd4, 64'h3000), '0);
		recover_once(2'd1, make_slot(1'b0, 1'b0, '0, 64'h1504, branch - 64'd8), '0);
		repeat (2) next_cycle();
		check_value("fetch_addr", fetch_addr, branch);
		next_cycle();
		check_value("fetch_addr", fetch_addr, 64'h3000);

		// counter at history 2a flips to taken, then back
		recover_once(2'd1, make_slot(1'b1, 1'b0, 6'h2a, 64'h1604, 64'h1c00), '0);
		check_value("pred_taken", 64'(pred_taken), 64'd1);
		recover_once(2'd1, make_slot(1'b1, 1'b0, 6'h2a, 64'h1604, 64'h1c00), '0);
		check_value("pred_taken", 64'(pred_taken), 64'd0);

		for (int i = 0; i < random_iters; i++) begin
			gap = $urandom_range(0, 4);
			hold = $urandom_range(1, 3);
			repeat (gap) begin
				drive_retire(retire_num_t'($urandom_range(0, 2)), 1'b0,
					random_slot(), random_slot());
				next_cycle();
			end
			repeat (hold) begin
				drive_retire(retire_num_t'($urandom_range(0, 2)), 1'b1,
					random_slot(), random_slot());
				next_cycle();
			end
		end
		drive_retire(2'd0, 1'b0, '0, '0);
		repeat (3) next_cycle();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
common/recover_pkg.sv
hw/recover.sv
predictor/bht.sv
predictor/btb.sv
hw/fetch_pc.sv
hw/frontend_top.sv
tests/frontend_tb.sv
